// ==== project.f ====
+incdir+design
design/icache_pkg.sv
design/mem_pkg.sv
design/icache_tag_store.sv
design/icache_data_ram.sv
design/icache_ctrl.sv
design/icache.sv
sim/icache_assertions.sv
sim/tb_clkgen.sv
sim/tb_checker.sv
sim/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - include_dirs:
      - design
    files:
      - design/icache_pkg.sv
      - design/mem_pkg.sv
      - design/icache_tag_store.sv
      - design/icache_data_ram.sv
      - design/icache_ctrl.sv
      - design/icache.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - sim/icache_assertions.sv
      - sim/tb_clkgen.sv
      - sim/tb_checker.sv
      - sim/tb_icache.sv

// ==== sim/tb_icache.sv ====
`timescale 1ns/1ns

`include "icache_defs.svh"

module tb_icache
    import mem_pkg::*;
();

    localparam int NUM_REQ      = 19;
    localparam int LIMIT_CYCLES = NUM_REQ * 20 + 50;

    // kind 0 miss, 1 hit, 2 either; way 2 leaves the victim open
    typedef struct packed {
        logic [31:0] addr;
        logic [1:0]  kind;
        logic [2:0]  gap;
        logic [1:0]  way;
    } req_row_t;

    req_row_t req_table [NUM_REQ] = '{
        '{32'h0000_1000, 2'd0, 3'd1, 2'd2},
        '{32'h0000_1004, 2'd1, 3'd0, 2'd2},
        '{32'h0000_2010, 2'd0, 3'd2, 2'd2},
        '{32'h0000_2014, 2'd1, 3'd0, 2'd2},
        '{32'h0000_0028, 2'd0, 3'd1, 2'd0},
        '{32'h0000_0228, 2'd0, 3'd0, 2'd1},
        '{32'h0000_002c, 2'd1, 3'd0, 2'd2},
        '{32'h0000_022c, 2'd1, 3'd0, 2'd2},
        '{32'h0000_0028, 2'd1, 3'd0, 2'd2},
        '{32'h0000_0428, 2'd0, 3'd1, 2'd2},
        '{32'h0000_0028, 2'd2, 3'd0, 2'd2},
        '{32'h0000_0228, 2'd2, 3'd0, 2'd2},
        '{32'h0001_0040, 2'd0, 3'd0, 2'd2},
        '{32'h0002_0048, 2'd0, 3'd3, 2'd2},
        '{32'h0003_0050, 2'd0, 3'd1, 2'd2},
        '{32'h0004_005c, 2'd0, 3'd0, 2'd2},
        '{32'h0005_0064, 2'd0, 3'd2, 2'd2},
        '{32'h0005_0060, 2'd1, 3'd0, 2'd2},
        '{32'h0000_1000, 2'd1, 3'd1, 2'd2}
    };

    logic clk, rst, valid, addr_ok, data_ok, rd_req, ret_valid;
    logic [`ICACHE_TAG_W-1:0]    tag;
    logic [`ICACHE_INDEX_W-1:0]  index;
    logic [`ICACHE_OFFSET_W-1:0] offset;
    logic [`ICACHE_WORD_W-1:0]   rdata;
    mem_addr_t   rd_addr;
    line_t       ret_data;
    logic [1:0]  exp_kind;
    int          err_cnt, check_cnt, refill_cnt, pending;
    int unsigned cyc = 0;
    integer      seed = 32'h96d2;

    tb_clkgen i_clkgen (.clk, .rst);

    icache i_icache (
        .clk, .rst, .valid, .tag, .index, .offset, .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .ret_valid, .ret_data
    );

    tb_checker i_checker (
        .clk, .rst, .valid, .addr_ok, .tag, .index, .offset, .exp_kind,
        .data_ok, .rdata, .rd_req, .rd_addr, .ret_valid,
        .err_cnt, .check_cnt, .refill_cnt, .pending
    );

    bind icache_ctrl icache_assertions i_assertions (
        .clk, .rst, .state, .rd_req, .ret_valid, .data_ok, .addr_ok
    );

    // word 1 in the upper half
    function automatic line_t memory_line(input mem_addr_t line_addr);
        return {line_addr + 32'd4, line_addr ^ 32'h5a5a_0000};
    endfunction

    // follows the replacement toggle, which flips on every edge out of reset
    always @(posedge clk) begin
        if (!rst) begin
            cyc <= cyc + 1;
        end
    end

    // memory with a random answer delay
    initial begin : responder
        int delay;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(posedge clk);
            if (!rst && rd_req) begin
                delay = {$random(seed)} % 6;
                repeat (delay) @(posedge clk);
                ret_valid <= 1'b1;
                ret_data  <= memory_line(rd_addr);
                @(posedge clk);
                ret_valid <= 1'b0;
            end
        end
    end

    // cache idle next cycle, and the accepting edge gives the wanted victim
    task automatic wait_for_way(input logic want);
        valid <= 1'b0;
        @(posedge clk);
        while (!((addr_ok || data_ok) && (cyc % 2) == want)) begin
            @(posedge clk);
        end
    endtask

    task automatic apply_table();
        for (int i = 0; i < NUM_REQ; i++) begin
            repeat (req_table[i].gap) begin
                valid <= 1'b0;
                @(posedge clk);
            end
            if (req_table[i].way != 2'd2) begin
                wait_for_way(req_table[i].way[0]);
            end
            valid               <= 1'b1;
            {tag, index, offset} <= req_table[i].addr;
            exp_kind            <= req_table[i].kind;
            @(posedge clk);
            while (!addr_ok) begin
                @(posedge clk);
            end
        end
        valid <= 1'b0;
    endtask

    initial begin : main
        int fails;
        valid    = 1'b0;
        tag      = '0;
        index    = '0;
        offset   = '0;
        exp_kind = 2'd0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        apply_table();
        @(posedge clk);
        while (pending != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        fails = i_icache.i_ctrl.i_assertions.fail_cnt;
        $display("%0d words checked, %0d refills, %0d checker errors, %0d assertion failures",
                 check_cnt, refill_cnt, err_cnt, fails);
        if (err_cnt == 0 && fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        #(LIMIT_CYCLES * 20);
        $display("timeout: run still busy after %0d cycles", LIMIT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== sim/tb_checker.sv ====
`timescale 1ns/1ns

`include "icache_defs.svh"

module tb_checker
    import mem_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid,
    input  logic                        addr_ok,
    input  logic [`ICACHE_TAG_W-1:0]    tag,
    input  logic [`ICACHE_INDEX_W-1:0]  index,
    input  logic [`ICACHE_OFFSET_W-1:0] offset,
    input  logic [1:0]                  exp_kind,
    input  logic                        data_ok,
    input  logic [`ICACHE_WORD_W-1:0]   rdata,
    input  logic                        rd_req,
    input  mem_addr_t                   rd_addr,
    input  logic                        ret_valid,
    output int                          err_cnt,
    output int                          check_cnt,
    output int                          refill_cnt,
    output int                          pending
);

    logic [31:0] word_q [$];
    logic [31:0] line_q [$];
    logic [1:0]  kind_q [$];
    int unsigned acc_q [$];
    int unsigned cyc, ret_cyc;
    logic        head_miss, rd_req_q;

    // memory rule applied to a request address
    function automatic logic [31:0] rule_word(input logic [31:0] addr);
        logic [31:0] line;
        line = {addr[31:3], 3'b000};
        return addr[2] ? line + 32'd4 : line ^ 32'h5a5a_0000;
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        err_cnt++;
        $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    endtask

    task automatic plain_error(input string msg);
        err_cnt++;
        $display("error at %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            err_cnt    = 0;
            check_cnt  = 0;
            refill_cnt = 0;
            cyc        = 0;
            head_miss  = 1'b0;
            rd_req_q   = 1'b0;
            pending   <= 0;
        end else begin
            // answer for the oldest request
            if (data_ok && word_q.size() == 0) begin
                plain_error("data_ok came with no request outstanding");
            end else if (data_ok) begin
                check_cnt++;
                if (rdata !== word_q[0]) begin
                    value_error("rdata", word_q[0], rdata);
                end
                // a hit leaves the fetch side open for the next request
                if (!head_miss && addr_ok !== 1'b1) begin
                    value_error("addr_ok", 1, addr_ok);
                end
                if (head_miss && kind_q[0] == 2'd1) begin
                    plain_error($sformatf("request %h missed but should hit", line_q[0]));
                end else if (!head_miss && kind_q[0] == 2'd0) begin
                    plain_error($sformatf("request %h hit but should miss", line_q[0]));
                end
                if (head_miss && cyc - ret_cyc != 2) begin
                    value_error("data_ok delay after ret_valid", 2, cyc - ret_cyc);
                end else if (!head_miss && cyc - acc_q[0] != 1) begin
                    value_error("data_ok delay after acceptance", 1, cyc - acc_q[0]);
                end
                void'(word_q.pop_front());
                void'(line_q.pop_front());
                void'(kind_q.pop_front());
                void'(acc_q.pop_front());
                head_miss = 1'b0;
            end
            // one line request per miss
            if (rd_req && !rd_req_q) begin
                refill_cnt++;
                if (word_q.size() == 0 || head_miss) begin
                    plain_error("memory request without a fresh miss");
                end else begin
                    if (rd_addr !== line_q[0]) begin
                        value_error("rd_addr", line_q[0], rd_addr);
                    end
                    head_miss = 1'b1;
                end
            end
            if (ret_valid) begin
                ret_cyc = cyc;
            end
            if (valid && addr_ok) begin
                word_q.push_back(rule_word({tag, index, offset}));
                line_q.push_back({tag, index, 3'b000});
                kind_q.push_back(exp_kind);
                acc_q.push_back(cyc);
            end
            rd_req_q = rd_req;
            cyc++;
            pending <= word_q.size();
        end
    end

endmodule

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset covers the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== sim/icache_assertions.sv ====
`timescale 1ns/1ns

module icache_assertions
    import icache_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input cache_state_e state,
    input logic         rd_req,
    input logic         ret_valid,
    input logic         data_ok,
    input logic         addr_ok
);

    int fail_cnt = 0;

    // line request held until memory answers
    assert property (@(posedge clk) disable iff (rst) rd_req && !ret_valid |=> rd_req)
        else begin
            $error("rd_req dropped before ret_valid");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (rst) state == MISS |-> !data_ok)
        else begin
            $error("data_ok raised while waiting for memory");
            fail_cnt++;
        end

    // no new request while a refill is open
    assert property (@(posedge clk) disable iff (rst) state inside {MISS, REPLACE} |-> !addr_ok)
        else begin
            $error("addr_ok high during a refill");
            fail_cnt++;
        end

endmodule

// ==== design/icache.sv ====
`timescale 1ns/1ns

`include "icache_defs.svh"

module icache
    import icache_pkg::*, mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    // fetch side
    input  logic                      valid,
    input  tag_t                      tag,
    input  index_t                    index,
    input  offset_t                   offset,
    output logic                      addr_ok,
    output logic                      data_ok,
    output logic [`ICACHE_WORD_W-1:0] rdata,
    // memory side
    output logic                      rd_req,
    output mem_addr_t                 rd_addr,
    input  logic                      ret_valid,
    input  line_t                     ret_data
);

    logic   tag_rd_en;
    index_t tag_rd_index;
    logic   tag_wr_en;
    way_t   tag_wr_way;
    index_t tag_wr_index;
    tag_t   tag_wr_tag;
    logic   way0_valid, way1_valid;
    tag_t   way0_tag, way1_tag;

    logic                        ram_en;
    logic                        ram_wen;
    index_t                      ram_addr;
    logic [2*`ICACHE_LINE_W-1:0] ram_wdata;
    logic [2*`ICACHE_LINE_W-1:0] ram_mask;
    logic [2*`ICACHE_LINE_W-1:0] ram_rdata;

    icache_ctrl i_ctrl (
        .clk, .rst,
        .valid, .tag, .index, .offset,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .ret_valid, .ret_data,
        .tag_rd_en, .tag_rd_index,
        .tag_wr_en, .tag_wr_way, .tag_wr_index, .tag_wr_tag,
        .way0_valid, .way1_valid, .way0_tag, .way1_tag,
        .ram_en, .ram_wen, .ram_addr, .ram_wdata, .ram_mask, .ram_rdata
    );

    icache_tag_store i_tag_store (
        .clk, .rst,
        .rd_en    (tag_rd_en),
        .rd_index (tag_rd_index),
        .wr_en    (tag_wr_en),
        .wr_way   (tag_wr_way),
        .wr_index (tag_wr_index),
        .wr_tag   (tag_wr_tag),
        .way0_valid, .way1_valid, .way0_tag, .way1_tag
    );

    icache_data_ram i_data_ram (
        .clk,
        .en       (ram_en),
        .wen      (ram_wen),
        .addr     (ram_addr),
        .wdata    (ram_wdata),
        .bit_mask (ram_mask),
        .rdata    (ram_rdata)
    );

endmodule

// ==== design/icache_ctrl.sv ====
`timescale 1ns/1ns

`include "icache_defs.svh"

module icache_ctrl
    import icache_pkg::*, mem_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    // fetch side
    input  logic                        valid,
    input  tag_t                        tag,
    input  index_t                      index,
    input  offset_t                     offset,
    output logic                        addr_ok,
    output logic                        data_ok,
    output logic [`ICACHE_WORD_W-1:0]   rdata,
    // memory side
    output logic                        rd_req,
    output mem_addr_t                   rd_addr,
    input  logic                        ret_valid,
    input  line_t                       ret_data,
    // tag store
    output logic                        tag_rd_en,
    output index_t                      tag_rd_index,
    output logic                        tag_wr_en,
    output way_t                        tag_wr_way,
    output index_t                      tag_wr_index,
    output tag_t                        tag_wr_tag,
    input  logic                        way0_valid,
    input  logic                        way1_valid,
    input  tag_t                        way0_tag,
    input  tag_t                        way1_tag,
    // data ram
    output logic                        ram_en,
    output logic                        ram_wen,
    output index_t                      ram_addr,
    output logic [2*`ICACHE_LINE_W-1:0] ram_wdata,
    output logic [2*`ICACHE_LINE_W-1:0] ram_mask,
    input  logic [2*`ICACHE_LINE_W-1:0] ram_rdata
);

    cache_state_e state, next_state;

    logic   accept;
    logic   way0_hit, way1_hit, cache_hit;
    logic   refill_done;
    logic   refill_wr;
    way_t   toggle, repl_way;
    tag_t   req_tag;
    index_t req_index;
    logic   req_word;
    line_t  hit_line, miss_line;

    assign addr_ok = (state == IDLE) || (state == LOOKUP && cache_hit);
    assign accept  = valid && addr_ok;

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag   <= tag;
            req_index <= index;
            req_word  <= offset[2];
        end
    end

    // compare against the buffered tag
    assign way0_hit  = way0_valid && (way0_tag == req_tag);
    assign way1_hit  = way1_valid && (way1_tag == req_tag);
    assign cache_hit = way0_hit || way1_hit;

    // way 1 lives in the upper half of the ram entry
    assign hit_line = way1_hit ? ram_rdata[2*`ICACHE_LINE_W-1:`ICACHE_LINE_W]
                               : ram_rdata[`ICACHE_LINE_W-1:0];

    // free-running victim choice
    always_ff @(posedge clk) begin
        if (rst) begin
            toggle <= 1'b0;
        end else begin
            toggle <= ~toggle;
        end
    end

    // victim is frozen when the miss is found
    always_ff @(posedge clk) begin
        if (state == LOOKUP && !cache_hit) begin
            repl_way <= toggle;
        end
    end

    // miss buffer
    always_ff @(posedge clk) begin
        if (state == MISS && ret_valid) begin
            miss_line <= ret_data;
        end
    end

    // first REPLACE cycle writes, second one answers
    always_ff @(posedge clk) begin
        if (rst) begin
            refill_done <= 1'b0;
        end else begin
            refill_done <= (state == REPLACE) && !refill_done;
        end
    end

    assign refill_wr = (state == REPLACE) && !refill_done;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!cache_hit) begin
                    next_state = MISS;
                end else if (!valid) begin
                    next_state = IDLE;
                end
            end
            MISS: begin
                if (ret_valid) begin
                    next_state = REPLACE;
                end
            end
            REPLACE: begin
                if (refill_done) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // fetch answer, hit data or the refilled line
    assign data_ok = (state == LOOKUP && cache_hit) || (state == REPLACE && refill_done);
    assign rdata   = (state == REPLACE) ? miss_line[req_word*`ICACHE_WORD_W +: `ICACHE_WORD_W]
                                        : hit_line[req_word*`ICACHE_WORD_W +: `ICACHE_WORD_W];

    // line request
    assign rd_req  = (state == MISS);
    assign rd_addr = {req_tag, req_index, {`ICACHE_OFFSET_W{1'b0}}};

    // tag store
    assign tag_rd_en    = accept;
    assign tag_rd_index = index;
    assign tag_wr_en    = refill_wr;
    assign tag_wr_way   = repl_way;
    assign tag_wr_index = req_index;
    assign tag_wr_tag   = req_tag;

    // data ram, line copied to both halves and masked to the victim way
    assign ram_en    = accept || refill_wr;
    assign ram_wen   = refill_wr;
    assign ram_addr  = refill_wr ? req_index : index;
    assign ram_wdata = {miss_line, miss_line};
    assign ram_mask  = {{`ICACHE_LINE_W{repl_way}}, {`ICACHE_LINE_W{~repl_way}}};

endmodule

// ==== design/icache_data_ram.sv ====
`timescale 1ns/1ns

`include "icache_defs.svh"

module icache_data_ram
    import icache_pkg::*;
(
    input  logic                       clk,
    input  logic                       en,
    input  logic                       wen,
    input  index_t                     addr,
    input  logic [2*`ICACHE_LINE_W-1:0] wdata,
    input  logic [2*`ICACHE_LINE_W-1:0] bit_mask,
    output logic [2*`ICACHE_LINE_W-1:0] rdata
);

    // one entry per set, way 1 in the upper half
    logic [2*`ICACHE_LINE_W-1:0] mem [`ICACHE_SETS];

    logic [2*`ICACHE_LINE_W-1:0] merged;

    // only masked bits take the new value
    assign merged = (mem[addr] & ~bit_mask) | (wdata & bit_mask);

    // single port, a write cycle does no read
    always_ff @(posedge clk) begin
        if (en && wen) begin
            mem[addr] <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (en && !wen) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== design/icache_tag_store.sv ====
`timescale 1ns/1ns

`include "icache_defs.svh"

module icache_tag_store
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    // lookup read
    input  logic   rd_en,
    input  index_t rd_index,
    // refill write
    input  logic   wr_en,
    input  way_t   wr_way,
    input  index_t wr_index,
    input  tag_t   wr_tag,
    // registered read data
    output logic   way0_valid,
    output logic   way1_valid,
    output tag_t   way0_tag,
    output tag_t   way1_tag
);

    // valid bits, one vector per way
    logic [`ICACHE_SETS-1:0] valid_q [2];

    // tag arrays
    tag_t tag_mem [2][`ICACHE_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
        end else if (wr_en) begin
            valid_q[wr_way][wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][wr_index] <= wr_tag;
        end
    end

    // valid outputs cleared so nothing hits straight out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            way0_valid <= 1'b0;
            way1_valid <= 1'b0;
        end else if (rd_en) begin
            way0_valid <= valid_q[0][rd_index];
            way1_valid <= valid_q[1][rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            way0_tag <= tag_mem[0][rd_index];
            way1_tag <= tag_mem[1][rd_index];
        end
    end

endmodule

// ==== design/mem_pkg.sv ====
`include "icache_defs.svh"

package mem_pkg;

    // word 0 sits in the low half
    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    // byte address, line aligned on requests
    typedef logic [`ICACHE_TAG_W+`ICACHE_INDEX_W+`ICACHE_OFFSET_W-1:0] mem_addr_t;

endpackage

// ==== design/icache_pkg.sv ====
`include "icache_defs.svh"

package icache_pkg;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE
    } cache_state_e;

    // address fields
    typedef logic [`ICACHE_TAG_W-1:0]    tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]  index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

    // two ways per set
    typedef logic way_t;

endpackage

// ==== design/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// byte address split, 32 bits in total
`define ICACHE_TAG_W    23
`define ICACHE_INDEX_W  6
`define ICACHE_OFFSET_W 3

// geometry
`define ICACHE_SETS     64

// one line holds two words
`define ICACHE_LINE_W   64
`define ICACHE_WORD_W   32

`endif
